//--- run_sim.sh
#!/bin/sh
# build and run the usb3 transfer engine testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_u3_transfer \
	-f sim.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run_sim: testbench reported failure"
	exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
	echo "run_sim: simulation ended without a result"
	exit 1
fi

//--- sim.f
+incdir+.
u3_pkg.sv
u3_flag_decode.sv
u3_urb_check.sv
u3_transfer_fsm.sv
u3_gpif_write.sv
u3_transfer.sv
tb_u3_transfer.sv

//--- tb_u3_transfer.sv
// testbench for the usb3 transfer engine, fifo and host models, monitor with checks
`timescale 1ns/1ns
`default_nettype none
`include "u3_defines.svh"

module tb_u3_transfer;

	localparam int NUM_PKTS   = 3;
	localparam int TOTAL_WDS  = 100 + 256 + 256;
	localparam int TIMEOUT    = 4 * TOTAL_WDS + 200 * NUM_PKTS;   // cycles
	localparam int DMA_WDS    = `U3_DMA_WORDS;
	localparam logic [31:0] FIRST_WORD = 32'h5a00_0001;

	logic                   clk;
	logic                   reset;
	logic                   fifo_rd;
	logic                   data_valid;
	logic [`U3_DATA_WD-1:0] fifo_data = FIRST_WORD;   // fifo head word
	logic                   fb_empty  = 1'b0;
	logic                   leader_flag;
	logic                   payload_flag;
	logic                   trailer_flag;
	u3_pkg::xfer_cfg_t      cfg;
	logic                   usb_flagb = 1'b1;            // host has room
	u3_pkg::gpif_out_t      gpif;
	logic                   change_flag;

	int exp_words [NUM_PKTS] = '{100, 256, 256};         // words per packet
	int exp_ends  [NUM_PKTS] = '{1, 2, 1};               // second packet adds a zlp

	int          errors = 0;
	int          pkt_done = 0;
	int          cycles = 0;
	logic [31:0] rnd = 32'hd495_e34b;
	logic        took = 1'b0;         // fifo word taken at the last edge
	logic        pull_req = 1'b0;     // ask host to cycle flagb
	int          host_wait = 0;
	int          host_low = 0;
	logic [31:0] exp_word = FIRST_WORD;
	int          pkt_wr, blk_wr, pkt_ends, falls_pending;
	logic [1:0]  prev_addr;
	logic        prev_flagb, prev_change;

	u3_transfer UUT
	(
		.clk                 (clk),
		.reset               (reset),
		.o_fifo_rd           (fifo_rd),
		.i_data_valid        (data_valid),
		.i_fifo_data         (fifo_data),
		.i_framebuffer_empty (fb_empty),
		.i_leader_flag       (leader_flag),
		.i_payload_flag      (payload_flag),
		.i_trailer_flag      (trailer_flag),
		.i_cfg               (cfg),
		.i_usb_flagb         (usb_flagb),
		.o_gpif              (gpif),
		.o_change_flag       (change_flag)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic note_mismatch(input string name, input logic [31:0] got,
	                             input logic [31:0] exp);
		errors++;
		$display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("error: %s at %0t", what, $time);
	endtask

	// --------------------------------------------------
	// fifo and host models
	// --------------------------------------------------
	always @(posedge clk)
		took <= fifo_rd && data_valid;

	always @(negedge clk)
	begin
		if (took)
			fifo_data <= fifo_data + 1'b1;   // next word falls through
		rnd      = xorshift(rnd);
		fb_empty <= (rnd[2:0] == 3'd0);      // gap about one cycle in eight
	end

	always @(negedge clk)
	begin
		if (reset)
		begin
			usb_flagb <= 1'b1;
			host_wait <= 0;
			host_low  <= 0;
		end
		else if (host_low > 0)
		begin
			host_low <= host_low - 1;
			if (host_low == 1)
				usb_flagb <= 1'b1;           // buffer drained, room again
		end
		else if (host_wait > 0)
		begin
			host_wait <= host_wait - 1;
			if (host_wait == 1)
			begin
				usb_flagb <= 1'b0;           // thread full
				host_low  <= 4;
			end
		end
		else if (pull_req)
			host_wait <= 3;
	end

	// --------------------------------------------------
	// monitor, all checks at the rising edge
	// --------------------------------------------------
	always @(posedge clk)
	begin
		pull_req <= 1'b0;
		if (reset)
		begin
			falls_pending = 0;
			prev_addr     = 2'b00;
			prev_flagb    = 1'b1;
			prev_change   = 1'b0;
			pkt_wr        = 0;
			blk_wr        = 0;
			pkt_ends      = 0;
		end
		else
		begin
			a_rd_empty: assert (!(fifo_rd && fb_empty))
				else note_failure("fifo read strobe high while the fifo is empty");
			if (prev_flagb && !usb_flagb)
				falls_pending++;
			if (!prev_flagb && usb_flagb)
				blk_wr = 0;                  // new dma block allowed
			prev_flagb = usb_flagb;
			if (gpif.fifoaddr != prev_addr)
			begin
				a_addr_fall: assert (falls_pending > 0)
					else note_failure("thread address changed without a flagb fall");
				a_addr_alt: assert (gpif.fifoaddr == (prev_addr ^ 2'b11))
					else note_mismatch("o_gpif.fifoaddr", gpif.fifoaddr, prev_addr ^ 2'b11);
				if (falls_pending > 0)
					falls_pending--;
				prev_addr = gpif.fifoaddr;
			end
			if (!gpif.slwr_n)
			begin
				a_data: assert (gpif.data == exp_word)
					else note_mismatch("o_gpif.data", gpif.data, exp_word);
				exp_word = exp_word + 1;
				pkt_wr++;
				blk_wr++;
				a_block: assert (blk_wr <= DMA_WDS)
					else note_failure("more dma writes than one block between flagb rises");
				if (pkt_done < NUM_PKTS && pkt_wr % DMA_WDS == 0 && pkt_wr != exp_words[pkt_done])
					pull_req <= 1'b1;        // block boundary inside the packet
			end
			else
			begin
				a_bus_idle: assert (gpif.data == '0)     // bus idles at zero
					else note_mismatch("o_gpif.data", gpif.data, 32'h0);
			end
			if (!gpif.pktend_n)
			begin
				if (pkt_ends == 1)
				begin
					a_zlp_strobe: assert (gpif.slwr_n)
						else note_mismatch("o_gpif.slwr_n in zlp", gpif.slwr_n, 32'h1);
				end
				pkt_ends++;
				pull_req <= 1'b1;
			end
			if (change_flag)
			begin
				a_single: assert (!prev_change)
					else note_failure("change flag high for more than one cycle");
				if (pkt_done < NUM_PKTS)
				begin
					a_words: assert (pkt_wr == exp_words[pkt_done])
						else note_mismatch("words per packet", pkt_wr, exp_words[pkt_done]);
					a_ends: assert (pkt_ends == exp_ends[pkt_done])
						else note_mismatch("o_gpif.pktend_n pulses", pkt_ends, exp_ends[pkt_done]);
				end
				else
					note_failure("change flag pulsed after the last packet");
				pkt_done++;
				pkt_wr   = 0;
				blk_wr   = 0;
				pkt_ends = 0;
			end
			prev_change = change_flag;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT)
		begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("%0d errors, %0d of %0d packets done", errors, pkt_done, NUM_PKTS);
			$display("Simulation failed");
			$finish;
		end
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);                      // first cycle out of reset
		a_idle: assert (gpif.slwr_n && gpif.pktend_n && gpif.fifoaddr == 2'b00 &&
		                !change_flag && !fifo_rd)
			else note_mismatch("{slwr_n,pktend_n,fifoaddr,change_flag,fifo_rd}",
			                   {gpif.slwr_n, gpif.pktend_n, gpif.fifoaddr, change_flag,
			                    fifo_rd},
			                   6'b110000);
	endtask

	task automatic wait_packet(input int n);
		while (pkt_done < n)
			@(negedge clk);
	endtask

	initial
	begin
		reset        = 1'b1;
		data_valid   = 1'b1;                 // fwft head always valid
		leader_flag  = 1'b0;
		payload_flag = 1'b0;
		trailer_flag = 1'b0;
		cfg.packet_size    = 32'd400;
		cfg.transfer_count = 32'd4;          // request 4 x 512 bytes
		cfg.transfer_size  = 32'd512;
		cfg.transfer1_size = 32'd0;
		cfg.transfer2_size = 32'd0;
		apply_reset();
		leader_flag = 1'b1;                  // 100 words, no payload
		wait_packet(1);
		@(negedge clk);
		leader_flag     = 1'b0;
		cfg.packet_size = 32'd1024;
		@(negedge clk);
		payload_flag = 1'b1;                 // 1 KiB, request larger
		wait_packet(2);
		@(negedge clk);
		payload_flag       = 1'b0;
		cfg.transfer_count = 32'd1;          // request now below packet size
		apply_reset();
		repeat (4) @(negedge clk);
		payload_flag = 1'b1;
		wait_packet(3);
		@(negedge clk);
		payload_flag = 1'b0;
		repeat (10) @(negedge clk);
		$display("%0d errors, %0d of %0d packets done", errors, pkt_done, NUM_PKTS);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- u3_defines.svh
// widths, dma block size and counter widths of the usb3 transfer engine
`ifndef U3_DEFINES_SVH
`define U3_DEFINES_SVH

// --------------------------------------------------
// gpif bus and control registers
// --------------------------------------------------
`define U3_DATA_WD      32      // gpif data word
`define U3_REG_WD       32      // control register word

// --------------------------------------------------
// dma block and packet counting
// --------------------------------------------------
// words per dma block, 8192 on hardware
`define U3_DMA_WORDS    64
`define U3_DMA_CNT_WD   14      // dma word counter, holds up to 8192
`define U3_PKT_CNT_WD   22      // packet word counter, packet bytes 23:2

`endif

//--- u3_flag_decode.sv
// flagb synchroniser with edge pulses, start flag edge detection
`timescale 1ns/1ns
`default_nettype none

module u3_flag_decode
(
	input  wire               clk,
	input  wire               reset,
	input  wire               i_usb_flagb,     // from the usb controller, async
	input  wire               i_leader_flag,
	input  wire               i_payload_flag,
	input  wire               i_trailer_flag,
	output u3_pkg::flag_evt_t o_evt
);

	// --------------------------------------------------
	// shift registers
	// --------------------------------------------------
	logic [2:0] flagb_sh;      // [1] is the usable level, [2] the previous one
	logic [1:0] leader_sh;
	logic [1:0] payload_sh;
	logic [1:0] trailer_sh;

	logic       rise_q;        // registered edge pulses
	logic       fall_q;
	logic       start_q;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flagb_sh   <= 3'b000;
			leader_sh  <= 2'b00;
			payload_sh <= 2'b00;
			trailer_sh <= 2'b00;
			rise_q     <= 1'b0;
			fall_q     <= 1'b0;
			start_q    <= 1'b0;
		end
		else
		begin
			flagb_sh   <= {flagb_sh[1:0], i_usb_flagb};
			leader_sh  <= {leader_sh[0], i_leader_flag};
			payload_sh <= {payload_sh[0], i_payload_flag};
			trailer_sh <= {trailer_sh[0], i_trailer_flag};
			rise_q     <= (flagb_sh[2:1] == 2'b01);   // host freed a buffer
			fall_q     <= (flagb_sh[2:1] == 2'b10);   // thread full
			// one start for leader, payload or trailer
			start_q    <= (leader_sh == 2'b01) || (payload_sh == 2'b01) ||
			              (trailer_sh == 2'b01);
		end
	end

	// level 2 cycles, pulses 3 cycles after the pin
	assign o_evt = '{flagb: flagb_sh[1], flagb_rise: rise_q, flagb_fall: fall_q,
	                 pkt_start: start_q};

	a_rise_fall_excl: assert property (@(posedge clk) disable iff (reset)
		!(o_evt.flagb_rise && o_evt.flagb_fall));

endmodule

`default_nettype wire

//--- u3_gpif_write.sv
// two stage gpif write pipeline, strobe and data aligned to the fifo read
`timescale 1ns/1ns
`default_nettype none
`include "u3_defines.svh"

module u3_gpif_write
(
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    i_accept,      // fifo word taken
	input  wire                    i_zlp_slot,    // hold strobe high for zlp
	input  wire [`U3_DATA_WD-1:0]  i_fifo_data,   // fwft data, valid with accept
	output logic                   o_slwr_n,
	output logic [`U3_DATA_WD-1:0] o_data
);

	// --------------------------------------------------
	// stage one
	// --------------------------------------------------
	logic                   wr_n_m;     // inverted accept
	logic [`U3_DATA_WD-1:0] data_m;

	always_ff @(posedge clk)
	begin
		if (reset)
			wr_n_m <= 1'b1;
		else
			wr_n_m <= ~i_accept;
	end

	always_ff @(posedge clk)
	begin
		data_m <= i_fifo_data;          // qualified by wr_n_m
	end

	// --------------------------------------------------
	// stage two, to the pins
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_slwr_n <= 1'b1;
			o_data   <= '0;
		end
		else
		begin
			o_slwr_n <= wr_n_m || i_zlp_slot;
			if (!wr_n_m)
				o_data <= data_m;
			else
				o_data <= '0;           // bus idles at zero
		end
	end

	// accepted word shows up two cycles later unless the zlp slot cut in
	a_write_align: assert property (@(posedge clk) disable iff (reset)
		i_accept ##1 !i_zlp_slot |=> !o_slwr_n);

endmodule

`default_nettype wire

//--- u3_pkg.sv
// state enum, flag event, control register and gpif pin types
`default_nettype none
`include "u3_defines.svh"

package u3_pkg;

	// --------------------------------------------------
	// transfer fsm states
	// --------------------------------------------------
	typedef enum logic [3:0]
	{
		IDLE,           // waiting for a start flag
		PACKET_START,   // wait for host thread ready
		DMA_SENDING,    // streaming fifo words to gpif
		CHECK_FLAG,     // dma block done, wait flagb rise
		PKT_END,        // strobe packet end
		WAIT_FLAG,      // wait before the zlp
		ADD_PKT_END,    // zero length packet
		DELAY,          // wait flagb to come back
		PACKET_STOP     // pulse change flag
	} xfer_state_e;

	// decoded buffer flag and start events
	typedef struct packed
	{
		logic flagb;        // synchronised level
		logic flagb_rise;   // one cycle pulse
		logic flagb_fall;   // one cycle pulse, thread full
		logic pkt_start;    // any of leader/payload/trailer rose
	} flag_evt_t;

	// control registers, all in bytes except the count
	typedef struct packed
	{
		logic [`U3_REG_WD-1:0] packet_size;
		logic [`U3_REG_WD-1:0] transfer_count;
		logic [`U3_REG_WD-1:0] transfer_size;
		logic [`U3_REG_WD-1:0] transfer1_size;
		logic [`U3_REG_WD-1:0] transfer2_size;
	} xfer_cfg_t;

	// gpif write port pins
	typedef struct packed
	{
		logic                   slwr_n;     // write strobe, active low
		logic                   pktend_n;   // packet end, active low
		logic [1:0]             fifoaddr;   // thread address, 00 or 11
		logic [`U3_DATA_WD-1:0] data;
	} gpif_out_t;

endpackage

`default_nettype wire

//--- u3_transfer.sv
// usb3 gpif transfer engine top, flag decode, request check, fsm, write stage
`timescale 1ns/1ns
`default_nettype none
`include "u3_defines.svh"

module u3_transfer
(
	input  wire                   clk,
	input  wire                   reset,
	// frame buffer fifo
	output logic                  o_fifo_rd,
	input  wire                   i_data_valid,
	input  wire [`U3_DATA_WD-1:0] i_fifo_data,
	input  wire                   i_framebuffer_empty,
	// packet start flags
	input  wire                   i_leader_flag,
	input  wire                   i_payload_flag,
	input  wire                   i_trailer_flag,
	// control registers and host flag
	input  u3_pkg::xfer_cfg_t     i_cfg,
	input  wire                   i_usb_flagb,
	// gpif pins, packet done
	output u3_pkg::gpif_out_t     o_gpif,
	output logic                  o_change_flag
);

	// --------------------------------------------------
	// internal wires
	// --------------------------------------------------
	u3_pkg::flag_evt_t      evt;
	logic                   zlp_allowed;
	logic                   accept;
	logic                   zlp_slot;
	logic                   pktend_n;
	logic [1:0]             fifoaddr;
	logic                   slwr_n;
	logic [`U3_DATA_WD-1:0] wr_data;

	u3_flag_decode u_flag_decode
	(
		.clk            (clk),
		.reset          (reset),
		.i_usb_flagb    (i_usb_flagb),
		.i_leader_flag  (i_leader_flag),
		.i_payload_flag (i_payload_flag),
		.i_trailer_flag (i_trailer_flag),
		.o_evt          (evt)
	);

	u3_urb_check u_urb_check
	(
		.clk            (clk),
		.reset          (reset),
		.i_payload_flag (i_payload_flag),
		.i_cfg          (i_cfg),
		.o_zlp_allowed  (zlp_allowed)
	);

	u3_transfer_fsm u_transfer_fsm
	(
		.clk                 (clk),
		.reset               (reset),
		.i_framebuffer_empty (i_framebuffer_empty),
		.i_data_valid        (i_data_valid),
		.i_zlp_allowed       (zlp_allowed),
		.i_evt               (evt),
		.i_pkt_bytes         (i_cfg.packet_size),
		.o_fifo_rd           (o_fifo_rd),
		.o_accept            (accept),
		.o_zlp_slot          (zlp_slot),
		.o_pktend_n          (pktend_n),
		.o_change_flag       (o_change_flag),
		.o_fifoaddr          (fifoaddr)
	);

	u3_gpif_write u_gpif_write
	(
		.clk         (clk),
		.reset       (reset),
		.i_accept    (accept),
		.i_zlp_slot  (zlp_slot),
		.i_fifo_data (i_fifo_data),
		.o_slwr_n    (slwr_n),
		.o_data      (wr_data)
	);

	// pin bundle, every field already registered
	assign o_gpif = '{slwr_n: slwr_n, pktend_n: pktend_n, fifoaddr: fifoaddr,
	                  data: wr_data};

endmodule

`default_nettype wire

//--- u3_transfer_fsm.sv
// packet and dma block fsm, word counters, fifo read, thread address, packet end
`timescale 1ns/1ns
`default_nettype none
`include "u3_defines.svh"

module u3_transfer_fsm
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   i_framebuffer_empty,
	input  wire                   i_data_valid,         // fwft word present
	input  wire                   i_zlp_allowed,
	input  u3_pkg::flag_evt_t     i_evt,
	input  wire [`U3_REG_WD-1:0]  i_pkt_bytes,          // packet size in bytes
	output logic                  o_fifo_rd,
	output logic                  o_accept,             // word taken this cycle
	output logic                  o_zlp_slot,           // zlp cycle coming
	output logic                  o_pktend_n,
	output logic                  o_change_flag,
	output logic [1:0]            o_fifoaddr
);

	localparam logic [`U3_DMA_CNT_WD-1:0] DMA_LAST = `U3_DMA_WORDS;

	u3_pkg::xfer_state_e        state;
	u3_pkg::xfer_state_e        next_state;

	logic [`U3_DMA_CNT_WD-1:0]  dma_cnt;      // words in current dma block
	logic [`U3_PKT_CNT_WD-1:0]  pkt_cnt;      // words in current packet
	logic [`U3_PKT_CNT_WD-1:0]  pkt_words;
	logic [1:0]                 addr_reg;     // thread address before output reg

	assign pkt_words = i_pkt_bytes[`U3_PKT_CNT_WD+1:2];   // bytes / 4

	// --------------------------------------------------
	// state register and next state
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			state <= u3_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			u3_pkg::IDLE:
				if (i_evt.pkt_start)
					next_state = u3_pkg::PACKET_START;
			u3_pkg::PACKET_START:
				if (i_evt.flagb)                    // thread has room
					next_state = u3_pkg::DMA_SENDING;
			u3_pkg::DMA_SENDING:
			begin
				if (pkt_cnt == pkt_words)           // packet end wins over block end
					next_state = u3_pkg::PKT_END;
				else if (dma_cnt == DMA_LAST)
					next_state = u3_pkg::CHECK_FLAG;
			end
			u3_pkg::CHECK_FLAG:
				if (i_evt.flagb_rise)
					next_state = u3_pkg::DMA_SENDING;
			u3_pkg::PKT_END:
				next_state = i_zlp_allowed ? u3_pkg::WAIT_FLAG : u3_pkg::DELAY;
			u3_pkg::WAIT_FLAG:
				if (i_evt.flagb_rise)
					next_state = u3_pkg::ADD_PKT_END;
			u3_pkg::ADD_PKT_END:
				next_state = u3_pkg::DELAY;         // zlp is a single strobe
			u3_pkg::DELAY:
				if (i_evt.flagb_rise)
					next_state = u3_pkg::PACKET_STOP;
			u3_pkg::PACKET_STOP:
				next_state = u3_pkg::IDLE;
			default:
				next_state = u3_pkg::IDLE;
		endcase
	end

	// --------------------------------------------------
	// fifo read, word accept
	// --------------------------------------------------
	// looks at next_state so the read starts one cycle early
	assign o_fifo_rd  = (next_state == u3_pkg::DMA_SENDING) && i_evt.flagb &&
	                    !i_framebuffer_empty && (dma_cnt < DMA_LAST);
	assign o_accept   = o_fifo_rd && i_data_valid;
	assign o_zlp_slot = (next_state == u3_pkg::ADD_PKT_END);

	// --------------------------------------------------
	// counters and registered outputs
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dma_cnt       <= '0;
			pkt_cnt       <= '0;
			addr_reg      <= 2'b00;
			o_pktend_n    <= 1'b1;
			o_change_flag <= 1'b0;
		end
		else
		begin
			// pulses by default, dma count only lives inside a block
			o_pktend_n    <= !((next_state == u3_pkg::PKT_END) ||
			                   (next_state == u3_pkg::ADD_PKT_END));
			o_change_flag <= (next_state == u3_pkg::PACKET_STOP);
			dma_cnt       <= '0;
			case (next_state)
				u3_pkg::IDLE:
					pkt_cnt <= '0;
				u3_pkg::DMA_SENDING:
				begin
					dma_cnt <= dma_cnt + (o_accept ? 1'b1 : 1'b0);
					pkt_cnt <= pkt_cnt + (o_accept ? 1'b1 : 1'b0);
				end
				u3_pkg::CHECK_FLAG, u3_pkg::WAIT_FLAG, u3_pkg::DELAY:
					if (i_evt.flagb_fall)
						addr_reg <= ~addr_reg;       // 00 <-> 11
				default:
					;
			endcase
		end
	end

	// extra stage so the address can sit in the io register
	always_ff @(posedge clk)
	begin
		if (reset)
			o_fifoaddr <= 2'b00;
		else
			o_fifoaddr <= addr_reg;
	end

	a_dma_bound: assert property (@(posedge clk) disable iff (reset)
		dma_cnt <= DMA_LAST);
	a_rd_not_empty: assert property (@(posedge clk) disable iff (reset)
		o_fifo_rd |-> !i_framebuffer_empty);

endmodule

`default_nettype wire

//--- u3_urb_check.sv
// host request size against packet size, zero length packet decision
`timescale 1ns/1ns
`default_nettype none
`include "u3_defines.svh"

module u3_urb_check
(
	input  wire               clk,
	input  wire               reset,
	input  wire               i_payload_flag,
	input  u3_pkg::xfer_cfg_t i_cfg,
	output logic              o_zlp_allowed
);

	// transfer registers, frozen outside reset
	logic [15:0]             count_q;      // only 16 bits go into the multiply
	logic [`U3_REG_WD-1:0]   size_q;
	logic [`U3_REG_WD-1:0]   size1_q;
	logic [`U3_REG_WD-1:0]   size2_q;

	logic [2*`U3_REG_WD-1:0] buf_size;     // size * count
	logic [`U3_REG_WD:0]     size12;       // transfer1 + transfer2, with carry
	logic [2*`U3_REG_WD-1:0] req_size;     // total host request in bytes

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count_q <= i_cfg.transfer_count[15:0];
			size_q  <= i_cfg.transfer_size;
			size1_q <= i_cfg.transfer1_size;
			size2_q <= i_cfg.transfer2_size;
		end
	end

	// --------------------------------------------------
	// request size, three register stages
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset)
			buf_size <= size_q * count_q;   // multiplier idle during reset
		size12   <= size1_q + size2_q;
		req_size <= buf_size + size12;
	end

	// zlp only for payload, request bigger than packet, packet a multiple of 1 KiB
	always_ff @(posedge clk)
	begin
		if (reset)
			o_zlp_allowed <= 1'b0;
		else
			o_zlp_allowed <= i_payload_flag &&
			                 (req_size > {{`U3_REG_WD{1'b0}}, i_cfg.packet_size}) &&
			                 (i_cfg.packet_size[9:2] == 8'h00);
	end

endmodule

`default_nettype wire
